//--- rgmii_rx_bridge.f
rtl/eth_link_pkg.sv
rtl/rgmii_lane_pkg.sv
rtl/rgmii_rx_capture.sv
rtl/inband_status_decoder.sv
rtl/gmii_rx_aligner.sv
rtl/rgmii_rx_bridge.sv
verification/rx_bridge_checker.sv
verification/tb_rgmii_rx_bridge.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_rgmii_rx_bridge
FILELIST  = rgmii_rx_bridge.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verification/tb_rgmii_rx_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rgmii_rx_bridge;

	// Frames per data test and the longest frame in bytes
	localparam int N_FRAMES    = 12;
	localparam int MAX_BYTES   = 16;
	// Worst case per test: speed set-up, nibble-wide frames, gaps
	localparam int TEST_CYCLES = 8 + N_FRAMES * (2 * MAX_BYTES + 8);
	localparam int RUN_CYCLES  = 6 * TEST_CYCLES + 100;

	logic                  gmii_rxc = 1'b0;
	logic                  oserdes_rst;
	logic [3:0]            rxd_rise;
	logic [3:0]            rxd_fall;
	logic                  rx_ctl_rise;
	logic                  rx_ctl_fall;
	logic [7:0]            gmii_rx_data;
	logic                  gmii_rx_en;
	logic                  gmii_rx_er;
	logic                  gmii_rx_dvalid;
	logic                  link_up;
	eth_link_pkg::lspeed_t link_speed;
	logic                  false_carrier;
	int                    test_id;
	int                    err_total;
	int                    tests_failed;
	logic [31:0]           rng;

	always #5 gmii_rxc = ~gmii_rxc;

	rgmii_rx_bridge #(.STATUS_STABLE_CYCLES(3)) i_rgmii_rx_bridge (.*);

	rx_bridge_checker #(.STABLE_CYCLES(3)) i_rx_bridge_checker (.*);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	////////////////////////////////////////////////////////////
	// Pin drivers, all on the falling edge

	// Falling control bit carries en ^ er, as on the wire
	task automatic drive(input logic en, input logic er, input logic [7:0] b);
		@(negedge gmii_rxc);
		rxd_rise    = b[3:0];
		rxd_fall    = b[7:4];
		rx_ctl_rise = en;
		rx_ctl_fall = en ^ er;
	endtask

	task automatic send_idles(input logic [7:0] st, input int n);
		repeat (n) drive(1'b0, 1'b0, st);
	endtask

	// Status idles to set the speed, then random frames and gaps
	task automatic run_frames(input logic [1:0] spd);
		logic [7:0] st;
		logic [7:0] b;
		int         nb;
		logic       odd;
		st = {5'b0, spd, 1'b1};
		send_idles(st, 4);
		repeat (N_FRAMES) begin
			rng = xorshift(rng);
			nb  = int'(rng[3:0]) + 1;
			// Some 10/100 frames end on a low nibble
			odd = rng[4];
			for (int i = 0; i < nb; i++) begin
				rng = xorshift(rng);
				b   = rng[7:0];
				if (spd == eth_link_pkg::LINK_SPEED_1000M) begin
					drive(1'b1, rng[10:8] == 3'd0, b);
				end else begin
					// Same nibble on both halves at 10/100
					drive(1'b1, rng[10:8] == 3'd0, {b[3:0], b[3:0]});
					if (!(odd && i == nb - 1))
						drive(1'b1, rng[13:11] == 3'd0, {b[7:4], b[7:4]});
				end
			end
			// Occasional idle error symbol in the gap
			if (rng[20])
				drive(1'b0, 1'b1, rng[31:24]);
			send_idles(st, int'(rng[17:16]) + 2);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence

	initial begin
		rng         = 32'd62;
		oserdes_rst = 1'b1;
		rxd_rise    = 4'h0;
		rxd_fall    = 4'h0;
		rx_ctl_rise = 1'b0;
		rx_ctl_fall = 1'b0;
		test_id     = 0;
		repeat (2) @(negedge gmii_rxc);
		oserdes_rst = 1'b0;
		// Reset values are checked while plain idles flow
		send_idles(8'h00, 4);

		// Random status runs of 1 to 4, reserved speeds included
		test_id = 1;
		repeat (20) begin
			rng = xorshift(rng);
			send_idles(rng[7:0], int'(rng[9:8]) + 1);
		end
		send_idles(8'h03, 3);
		// Reserved speed and idle error each restart a run
		send_idles(8'h05, 2);
		send_idles(8'h07, 1);
		send_idles(8'h05, 2);
		drive(1'b0, 1'b1, 8'h05);
		send_idles(8'h05, 2);
		send_idles(8'h03, 3);

		// Idle error symbols, about half of them the false carrier code
		test_id = 2;
		repeat (24) begin
			rng = xorshift(rng);
			if (rng[0])
				drive(1'b0, 1'b1, rgmii_lane_pkg::FALSE_CARRIER_CODE);
			else
				drive(1'b0, 1'b1, rng[15:8]);
			drive(1'b0, 1'b0, 8'h03);
		end
		send_idles(8'h03, 3);

		test_id = 3;
		run_frames(eth_link_pkg::LINK_SPEED_1000M);
		test_id = 4;
		run_frames(eth_link_pkg::LINK_SPEED_100M);
		test_id = 5;
		run_frames(eth_link_pkg::LINK_SPEED_10M);

		// Let the checker close the last test
		test_id = 6;
		repeat (3) @(posedge gmii_rxc);
		$display("tests 6, failed %0d, errors %0d", tests_failed, err_total);
		if (tests_failed == 0 && err_total == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

	// Watchdog sized from the worst-case stimulus length
	initial begin
		#(RUN_CYCLES * 10);
		$display("watchdog expired after %0d cycles, stimulus never finished", RUN_CYCLES);
		$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- verification/rx_bridge_checker.sv
`timescale 1ns/1ps
`default_nettype none

module rx_bridge_checker #(
	parameter int STABLE_CYCLES = 3
) (
	input  logic                  gmii_rxc,
	input  logic                  oserdes_rst,
	input  logic [3:0]            rxd_rise,
	input  logic [3:0]            rxd_fall,
	input  logic                  rx_ctl_rise,
	input  logic                  rx_ctl_fall,
	input  logic [7:0]            gmii_rx_data,
	input  logic                  gmii_rx_en,
	input  logic                  gmii_rx_er,
	input  logic                  gmii_rx_dvalid,
	input  logic                  link_up,
	input  eth_link_pkg::lspeed_t link_speed,
	input  logic                  false_carrier,
	input  int                    test_id,
	output int                    err_total,
	output int                    tests_failed
);

	// Expected outputs: {data[7:0], en, er, dvalid, link_up, speed[1:0], fc}
	logic [14:0] pend;
	logic [14:0] cur;
	// Model state: nibble pairing and status debounce
	logic        m_hi;
	logic [3:0]  m_lo;
	logic        m_up;
	logic [1:0]  m_spd;
	logic [7:0]  m_cand;
	int          m_cnt;
	logic        armed = 1'b0;
	int          cur_test = 0;
	int          shown_test = 0;
	int          test_errs = 0;
	int          n_err = 0;
	int          n_fail = 0;

	assign err_total    = n_err;
	assign tests_failed = n_fail;

	function automatic string test_name(input int id);
		case (id)
			0:       return "reset_state";
			1:       return "inband_status";
			2:       return "false_carrier";
			3:       return "gigabit_frames";
			4:       return "fast_100m";
			default: return "slow_10m";
		endcase
	endfunction

	////////////////////////////////////////////////////////////
	// Reference model, one pin sample per call

	task automatic step(input logic en, input logic xr, input logic [7:0] b,
			output logic [14:0] e);
		logic       dv;
		logic [7:0] d;
		logic       fc;
		dv = 1'b0;
		d  = 8'h00;
		// Data path runs on the speed committed before this sample
		if (m_spd == eth_link_pkg::LINK_SPEED_1000M) begin
			dv   = en;
			d    = b;
			m_hi = 1'b0;
		end else if (en && m_hi) begin
			dv   = 1'b1;
			d    = {b[3:0], m_lo};
			m_hi = 1'b0;
		end else begin
			if (en)
				m_lo = b[3:0];
			m_hi = en;
		end
		fc = !en && xr && (b == rgmii_lane_pkg::FALSE_CARRIER_CODE);
		// Frame data, idle errors and speed code 3 break a run
		if (en || xr || b[2:1] == 2'd3) begin
			m_cnt = 0;
		end else begin
			if (m_cnt > 0 && b == m_cand)
				m_cnt = (m_cnt < STABLE_CYCLES) ? m_cnt + 1 : STABLE_CYCLES;
			else
				m_cnt = 1;
			m_cand = b;
			if (m_cnt == STABLE_CYCLES) begin
				m_up  = b[0];
				m_spd = b[2:1];
			end
		end
		e = {d, en, en && xr, dv, m_up, m_spd, fc};
	endtask

	// Pins are stable at the rising edge
	always @(posedge gmii_rxc) begin
		cur_test = test_id;
		if (oserdes_rst) begin
			m_hi   = 1'b0;
			m_lo   = 4'h0;
			m_up   = 1'b0;
			m_spd  = 2'd0;
			m_cand = 8'h00;
			m_cnt  = 0;
			cur    = '0;
			// First edge after reset sees an all-zero symbol
			step(1'b0, 1'b0, 8'h00, pend);
			armed  = 1'b1;
		end else begin
			cur = pend;
			step(rx_ctl_rise, rx_ctl_rise ^ rx_ctl_fall, {rxd_fall, rxd_rise}, pend);
		end
	end

	////////////////////////////////////////////////////////////
	// Comparison at the falling edge

	task automatic compare(input string what, input logic [7:0] exp, input logic [7:0] act);
		if (exp !== act) begin
			$display("ERR %s %s expected %02h actual %02h at %0t",
				test_name(cur_test), what, exp, act, $time);
			test_errs++;
			n_err++;
		end
	endtask

	task automatic flag(input string msg);
		$display("%s: %s at %0t", test_name(cur_test), msg, $time);
		test_errs++;
		n_err++;
	endtask

	always @(negedge gmii_rxc) begin
		if (armed) begin
			// Close the finished test before checking the new one
			if (cur_test != shown_test) begin
				$display("test %-15s %s, %0d errors", test_name(shown_test),
					(test_errs == 0) ? "ok" : "FAILED", test_errs);
				if (test_errs != 0)
					n_fail++;
				test_errs  = 0;
				shown_test = cur_test;
			end
			compare("gmii_rx_en", 8'(cur[6]), 8'(gmii_rx_en));
			compare("gmii_rx_er", 8'(cur[5]), 8'(gmii_rx_er));
			compare("link_up", 8'(cur[3]), 8'(link_up));
			compare("link_speed", 8'(cur[2:1]), 8'(link_speed));
			compare("false_carrier", 8'(cur[0]), 8'(false_carrier));
			// Data only counts where a byte is due
			if (cur[4] && !gmii_rx_dvalid)
				flag($sformatf("missing dvalid, byte %02h never delivered", cur[14:7]));
			else if (!cur[4] && gmii_rx_dvalid)
				flag("extra dvalid with no byte due");
			else if (cur[4])
				compare("gmii_rx_data", cur[14:7], gmii_rx_data);
		end
	end

endmodule

`default_nettype wire

//--- rtl/rgmii_rx_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module rgmii_rx_bridge #(
	parameter int STATUS_STABLE_CYCLES = 3
) (
	input  logic                                gmii_rxc,
	input  logic                                oserdes_rst,
	input  logic [rgmii_lane_pkg::NIBBLE_W-1:0] rxd_rise,
	input  logic [rgmii_lane_pkg::NIBBLE_W-1:0] rxd_fall,
	input  logic                                rx_ctl_rise,
	input  logic                                rx_ctl_fall,
	output logic [rgmii_lane_pkg::BYTE_W-1:0]   gmii_rx_data,
	output logic                                gmii_rx_en,
	output logic                                gmii_rx_er,
	output logic                                gmii_rx_dvalid,
	output logic                                link_up,
	output eth_link_pkg::lspeed_t               link_speed,
	output logic                                false_carrier
);

	// Captured symbol, shared by decoder and aligner
	eth_link_pkg::rx_symbol_u sym;
	logic                     sym_en;
	logic                     sym_ctl_xor;

	////////////////////////////////////////////////////////////
	// Pin capture

	rgmii_rx_capture i_rgmii_rx_capture (
		.gmii_rxc    (gmii_rxc),
		.oserdes_rst (oserdes_rst),
		.rxd_rise    (rxd_rise),
		.rxd_fall    (rxd_fall),
		.rx_ctl_rise (rx_ctl_rise),
		.rx_ctl_fall (rx_ctl_fall),
		.sym         (sym),
		.sym_en      (sym_en),
		.sym_ctl_xor (sym_ctl_xor)
	);

	////////////////////////////////////////////////////////////
	// In-band status, side by side with the data path

	inband_status_decoder #(
		.STATUS_STABLE_CYCLES (STATUS_STABLE_CYCLES)
	) i_inband_status_decoder (
		.gmii_rxc      (gmii_rxc),
		.oserdes_rst   (oserdes_rst),
		.sym           (sym),
		.sym_en        (sym_en),
		.sym_ctl_xor   (sym_ctl_xor),
		.link_up       (link_up),
		.link_speed    (link_speed),
		.false_carrier (false_carrier)
	);

	// Aligner picks its mode from the decoded speed
	gmii_rx_aligner i_gmii_rx_aligner (
		.gmii_rxc       (gmii_rxc),
		.oserdes_rst    (oserdes_rst),
		.sym            (sym),
		.sym_en         (sym_en),
		.sym_ctl_xor    (sym_ctl_xor),
		.link_speed     (link_speed),
		.gmii_rx_data   (gmii_rx_data),
		.gmii_rx_en     (gmii_rx_en),
		.gmii_rx_er     (gmii_rx_er),
		.gmii_rx_dvalid (gmii_rx_dvalid)
	);

endmodule

`default_nettype wire

//--- rtl/gmii_rx_aligner.sv
`timescale 1ns/1ps
`default_nettype none

module gmii_rx_aligner (
	input  logic                              gmii_rxc,
	input  logic                              oserdes_rst,
	input  eth_link_pkg::rx_symbol_u          sym,
	input  logic                              sym_en,
	input  logic                              sym_ctl_xor,
	input  eth_link_pkg::lspeed_t             link_speed,
	output logic [rgmii_lane_pkg::BYTE_W-1:0] gmii_rx_data,
	output logic                              gmii_rx_en,
	output logic                              gmii_rx_er,
	output logic                              gmii_rx_dvalid
);

	logic                                gig_mode;
	// Set when the next enabled nibble is the high half
	logic                                hi_phase;
	logic [rgmii_lane_pkg::NIBBLE_W-1:0] lo_nib;

	// Speed is sampled as each symbol arrives
	// It only changes between frames
	assign gig_mode = (link_speed == eth_link_pkg::LINK_SPEED_1000M);

	////////////////////////////////////////////////////////////
	// Output register, two cycles after the pin sample

	always_ff @(posedge gmii_rxc) begin
		if (oserdes_rst) begin
			gmii_rx_data   <= '0;
			gmii_rx_en     <= 1'b0;
			gmii_rx_er     <= 1'b0;
			gmii_rx_dvalid <= 1'b0;
			hi_phase       <= 1'b0;
		end else begin
			// Enable and error follow the pins in every mode
			gmii_rx_en <= sym_en;
			gmii_rx_er <= sym_en && sym_ctl_xor;

			if (gig_mode) begin
				// Full byte every cycle
				gmii_rx_data   <= sym.data;
				gmii_rx_dvalid <= sym_en;
				hi_phase       <= 1'b0;
			end else begin
				// One nibble per cycle, byte ready on the high half
				gmii_rx_dvalid <= sym_en && hi_phase;

				// Idle clears the phase, so the first enabled cycle
				// after each enable rise is always a low nibble
				hi_phase <= sym_en && !hi_phase;

				if (sym_en && hi_phase)
					gmii_rx_data <= {sym.data[rgmii_lane_pkg::NIBBLE_W-1:0], lo_nib};
			end
		end
	end

	// Low nibble waits here for its partner
	// rxd_fall repeats the same nibble at 10/100 and is not used
	always_ff @(posedge gmii_rxc) begin
		if (sym_en && !hi_phase)
			lo_nib <= sym.data[rgmii_lane_pkg::NIBBLE_W-1:0];
	end

	////////////////////////////////////////////////////////////
	// Checks

	a_dvalid_in_frame: assert property (@(posedge gmii_rxc) disable iff (oserdes_rst)
		gmii_rx_dvalid |-> gmii_rx_en);

	// Nibble pairing gives at most every other cycle at 10/100
	a_slow_dvalid_gap: assert property (@(posedge gmii_rxc) disable iff (oserdes_rst)
		(gmii_rx_dvalid && !gig_mode) |=> !gmii_rx_dvalid);

endmodule

`default_nettype wire

//--- rtl/inband_status_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module inband_status_decoder #(
	parameter int STATUS_STABLE_CYCLES = 3
) (
	input  logic                     gmii_rxc,
	input  logic                     oserdes_rst,
	input  eth_link_pkg::rx_symbol_u sym,
	input  logic                     sym_en,
	input  logic                     sym_ctl_xor,
	output logic                     link_up,
	output eth_link_pkg::lspeed_t    link_speed,
	output logic                     false_carrier
);

	// Run counter saturates at the required length
	localparam int               CNT_W   = $clog2(STATUS_STABLE_CYCLES + 1);
	localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(STATUS_STABLE_CYCLES);

	eth_link_pkg::inband_status_t cand;
	logic [CNT_W-1:0]             run_cnt;
	logic [CNT_W-1:0]             run_cnt_next;
	logic                         idle_sym;
	logic                         speed_ok;

	////////////////////////////////////////////////////////////
	// Run length of identical status symbols

	// Plain idle: enable low and no error flag
	assign idle_sym = !sym_en && !sym_ctl_xor;

	// Reserved speed code never counts toward a run
	assign speed_ok = sym.status.speed inside {eth_link_pkg::LINK_SPEED_10M,
		eth_link_pkg::LINK_SPEED_100M, eth_link_pkg::LINK_SPEED_1000M};

	always_comb begin
		// Frame data, idle errors and reserved codes break the run
		if (!idle_sym || !speed_ok)
			run_cnt_next = '0;
		// Same status as last time, extend the run
		else if ((run_cnt != '0) && (sym.status == cand))
			run_cnt_next = (run_cnt == CNT_MAX) ? CNT_MAX : run_cnt + 1'b1;
		// New candidate starts a fresh run
		else
			run_cnt_next = CNT_W'(1);
	end

	// Candidate is only compared while the run count is nonzero
	always_ff @(posedge gmii_rxc) begin
		if (idle_sym && speed_ok)
			cand <= sym.status;
	end

	////////////////////////////////////////////////////////////
	// Committed link state and false carrier flag

	always_ff @(posedge gmii_rxc) begin
		if (oserdes_rst) begin
			run_cnt       <= '0;
			link_up       <= 1'b0;
			link_speed    <= eth_link_pkg::LINK_SPEED_10M;
			false_carrier <= 1'b0;
		end else begin
			run_cnt <= run_cnt_next;

			// Run complete, take the status now
			if (run_cnt_next == CNT_MAX) begin
				link_up    <= sym.status.link_up;
				link_speed <= sym.status.speed;
			end

			// One-cycle pulse per false carrier symbol
			false_carrier <= !sym_en && sym_ctl_xor &&
				(sym.data == rgmii_lane_pkg::FALSE_CARRIER_CODE);
		end
	end

	// Reserved codes are filtered before commit, so the output never holds one
	a_speed_valid: assert property (@(posedge gmii_rxc) disable iff (oserdes_rst)
		link_speed inside {eth_link_pkg::LINK_SPEED_10M,
			eth_link_pkg::LINK_SPEED_100M, eth_link_pkg::LINK_SPEED_1000M});

endmodule

`default_nettype wire

//--- rtl/rgmii_rx_capture.sv
`timescale 1ns/1ps
`default_nettype none

module rgmii_rx_capture (
	input  logic                                gmii_rxc,
	input  logic                                oserdes_rst,
	input  logic [rgmii_lane_pkg::NIBBLE_W-1:0] rxd_rise,
	input  logic [rgmii_lane_pkg::NIBBLE_W-1:0] rxd_fall,
	input  logic                                rx_ctl_rise,
	input  logic                                rx_ctl_fall,
	output eth_link_pkg::rx_symbol_u            sym,
	output logic                                sym_en,
	output logic                                sym_ctl_xor
);

	////////////////////////////////////////////////////////////
	// DDR halves to one SDR symbol

	// Both halves of a pin cycle come in together on the rising edge
	// Symbol is valid one cycle after the pin sample
	always_ff @(posedge gmii_rxc) begin
		if (oserdes_rst) begin
			sym         <= '0;
			sym_en      <= 1'b0;
			sym_ctl_xor <= 1'b0;
		end else begin
			// Rising half is the low nibble, falling half the high one
			sym.data    <= {rxd_fall, rxd_rise};

			// Rising control bit is plain enable
			sym_en      <= rx_ctl_rise;

			// Falling control bit is sent as en ^ er
			// so a steady line does not toggle
			// The xor here recovers er for frames and the
			// idle error flag between frames
			sym_ctl_xor <= rx_ctl_rise ^ rx_ctl_fall;
		end
	end

endmodule

`default_nettype wire

//--- rtl/rgmii_lane_pkg.sv
`default_nettype none

package rgmii_lane_pkg;

	// One DDR half of the RGMII data lane
	localparam int NIBBLE_W = 4;

	// Both halves together rebuild one GMII byte
	localparam int BYTE_W = 2 * NIBBLE_W;

	// Idle with error set, this code means false carrier
	localparam logic [BYTE_W-1:0] FALSE_CARRIER_CODE = 8'h0E;

endpackage

`default_nettype wire

//--- rtl/eth_link_pkg.sv
`default_nettype none

package eth_link_pkg;

	////////////////////////////////////////////////////////////
	// Link speed as reported in-band by the PHY

	// Encoding follows the RGMII inter-frame status bits [2:1]
	typedef enum logic [1:0] {
		LINK_SPEED_10M   = 2'd0,
		LINK_SPEED_100M  = 2'd1,
		LINK_SPEED_1000M = 2'd2
		// 2'd3 is reserved and never committed
	} lspeed_t;

	////////////////////////////////////////////////////////////
	// Captured symbol views

	// Inter-frame status byte, link_up lands in bit 0
	typedef struct packed {
		logic [4:0] spare;
		lspeed_t    speed;
		logic       link_up;
	} inband_status_t;

	// Same byte is frame data while enable is high
	// and link status while enable is low
	typedef union packed {
		logic [7:0]     data;
		inband_status_t status;
	} rx_symbol_u;

endpackage

`default_nettype wire
